// File: rvCore.f
+incdir+rtl
rtl/rvPkg.sv
rtl/rvDecoder.sv
rtl/rvAlu.sv
rtl/rvRegFile.sv
rtl/rvPcCounter.sv
rtl/rvSequencer.sv
rtl/rvCore.sv
verif/rvMemModel.sv
verif/rvCoreTb.sv

// File: run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert --top-module rvCoreTb -f rvCore.f -o rvCoreSim

# The simulator status is not trusted on its own, the log decides
./obj_dir/rvCoreSim 2>&1 | tee sim.log || true

grep -q "^TEST PASS$" sim.log
echo "rvCore simulation passed"

// File: verif/rvCoreTb.sv
module rvCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [6:0] opImm  = 7'b0010011;
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opJalr = 7'b1100111;
    localparam int worstWait = 4;   // Clocks per bus access at most

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
    } storeT;

    logic            rstn = 1'b0;
    logic            rst = 1'b1;
    rvPkg::wbMasterT dutOut;
    rvPkg::wbSlaveT  memResp;
    logic            halted;
    logic [31:0]     prog [$];
    storeT           expStores [$];
    int              storeIdx = 0;
    int              cycles = 0;
    int              timeoutLimit = 0;

    rvCore i_dut (
        .rstn   (rstn),
        .rst    (rst),
        .wbIn   (memResp),
        .wbOut  (dutOut),
        .halted (halted)
    );

    rvMemModel i_mem (
        .rstn (rstn),
        .rst  (rst),
        .req  (dutOut),
        .resp (memResp)
    );

    initial begin
        forever #5 rstn = ~rstn;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Background memory word unique to its address
    function automatic logic [31:0] fillWord(input logic [9:0] idx);
        return {6'h2A, idx, 6'h15, idx};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // SW through x0 to an absolute address and the bus write it must cause
    task automatic emitStore(input logic [4:0] rs, input logic [11:0] adr,
                             input logic [31:0] dat);
        storeT s;
        s.adr = {20'd0, adr};
        s.dat = dat;
        emit(encS(rs, 5'd0, adr));
        expStores.push_back(s);
    endtask

    // Never executed when control flow is right
    task automatic emitDeadStore();
        emit(encS(5'd13, 5'd0, 12'h7F0));
    endtask

    task automatic emitBranchPair(input logic [2:0] f3, input logic [4:0] tA,
                                  input logic [4:0] tB, input logic [4:0] nA,
                                  input logic [4:0] nB, input logic [11:0] adr);
        emit(encB(f3, tA, tB, 13'd8));
        emitDeadStore();
        emit(encB(f3, nA, nB, 13'd8));
        emitStore(5'd13, adr, 32'h0000_005A);   // Fall-through marker
    endtask

    task automatic buildProgram();
        int jalAdr;
        int jalrAdr;
        emit(encI(opImm, 3'd0, 5'd1, 5'd0, 12'd5));      // x1 = 5
        emit(encI(opImm, 3'd0, 5'd2, 5'd0, 12'hFFD));    // x2 = -3
        emit(encR(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
        emitStore(5'd3, 12'h400, 32'h0000_0002);
        emit(encR(7'h20, 3'd0, 5'd4, 5'd0, 5'd1));       // SUB wraps below zero
        emitStore(5'd4, 12'h404, 32'hFFFF_FFFB);
        emit(encR(7'h00, 3'd2, 5'd5, 5'd2, 5'd1));
        emitStore(5'd5, 12'h408, 32'h0000_0001);
        emit(encR(7'h00, 3'd3, 5'd6, 5'd2, 5'd1));       // SLTU sees a large value
        emitStore(5'd6, 12'h40C, 32'h0000_0000);
        emit(encR(7'h20, 3'd5, 5'd7, 5'd2, 5'd1));
        emitStore(5'd7, 12'h410, 32'hFFFF_FFFF);
        emit(encR(7'h00, 3'd5, 5'd8, 5'd2, 5'd1));
        emitStore(5'd8, 12'h414, 32'h07FF_FFFF);
        emit(encR(7'h00, 3'd7, 5'd9, 5'd1, 5'd2));
        emitStore(5'd9, 12'h418, 32'h0000_0005);
        emit(encR(7'h00, 3'd6, 5'd9, 5'd1, 5'd2));
        emitStore(5'd9, 12'h41C, 32'hFFFF_FFFD);
        emit(encR(7'h00, 3'd4, 5'd9, 5'd1, 5'd2));
        emitStore(5'd9, 12'h420, 32'hFFFF_FFF8);
        emit(encR(7'h00, 3'd1, 5'd9, 5'd1, 5'd1));
        emitStore(5'd9, 12'h424, 32'h0000_00A0);
        emit(encI(opImm, 3'd7, 5'd10, 5'd2, 12'hFF0));
        emitStore(5'd10, 12'h428, 32'hFFFF_FFF0);
        emit(encI(opImm, 3'd6, 5'd10, 5'd1, 12'hF00));
        emitStore(5'd10, 12'h42C, 32'hFFFF_FF05);
        emit(encI(opImm, 3'd4, 5'd10, 5'd1, 12'hFFF));
        emitStore(5'd10, 12'h430, 32'hFFFF_FFFA);
        emit(encI(opImm, 3'd2, 5'd10, 5'd2, 12'hFFE));
        emitStore(5'd10, 12'h434, 32'h0000_0001);
        emit(encI(opImm, 3'd3, 5'd10, 5'd1, 12'hFFF));   // SLTIU against all ones
        emitStore(5'd10, 12'h438, 32'h0000_0001);
        emit(encI(opImm, 3'd1, 5'd10, 5'd1, 12'h01C));
        emitStore(5'd10, 12'h43C, 32'h5000_0000);
        emit(encI(opImm, 3'd5, 5'd10, 5'd2, 12'h01C));
        emitStore(5'd10, 12'h440, 32'h0000_000F);
        emit(encI(opImm, 3'd5, 5'd10, 5'd2, 12'h401));   // SRAI by one
        emitStore(5'd10, 12'h444, 32'hFFFF_FFFE);
        emit(encI(opImm, 3'd0, 5'd0, 5'd1, 12'd7));
        emitStore(5'd0, 12'h448, 32'h0000_0000);
        emit(encI(opLoad, 3'd2, 5'd11, 5'd0, 12'h600));
        emit(encI(opImm, 3'd0, 5'd12, 5'd11, 12'd1));
        emitStore(5'd12, 12'h44C, fillWord(10'h180) + 32'd1);
        emit(encI(opImm, 3'd0, 5'd13, 5'd0, 12'h05A));
        emitBranchPair(3'd0, 5'd1, 5'd1, 5'd1, 5'd2, 12'h450);
        emitBranchPair(3'd1, 5'd1, 5'd2, 5'd1, 5'd1, 12'h454);
        emitBranchPair(3'd4, 5'd2, 5'd1, 5'd1, 5'd2, 12'h458);
        emitBranchPair(3'd5, 5'd1, 5'd2, 5'd2, 5'd1, 12'h45C);
        emitBranchPair(3'd6, 5'd1, 5'd2, 5'd2, 5'd1, 12'h460);
        emitBranchPair(3'd7, 5'd2, 5'd1, 5'd1, 5'd2, 12'h464);
        jalAdr = 4 * prog.size();
        emit(encJ(5'd15, 21'd8));
        emitDeadStore();
        emitStore(5'd15, 12'h468, 32'(jalAdr + 4));
        jalrAdr = 4 * (prog.size() + 1);
        emit(encI(opImm, 3'd0, 5'd16, 5'd0, 12'(jalrAdr + 8)));
        emit(encI(opJalr, 3'd0, 5'd17, 5'd16, 12'd8));   // Skips three words
        emitDeadStore();
        emitDeadStore();
        emitDeadStore();
        emitStore(5'd17, 12'h46C, 32'(jalrAdr + 4));
        emit(32'h0000_0000);   // Illegal, halts the core
    endtask

    task automatic loadMemory();
        for (int i = 0; i < 1024; i++) begin
            i_mem.mem[i[9:0]] = fillWord(i[9:0]);
        end
        foreach (prog[k]) begin
            i_mem.mem[k[9:0]] = prog[k];
        end
    endtask

    // Every bus write is compared with the next expected store
    always @(posedge rstn) begin
        if (!rst && dutOut.cyc && dutOut.stb && memResp.ack) begin
            checkEq("wbOut.sel", 32'(dutOut.sel), 32'h0000_000F);   // Full words only
        end
        if (!rst && dutOut.cyc && dutOut.stb && dutOut.we && memResp.ack) begin
            if (storeIdx >= expStores.size()) begin
                failRun($sformatf("unexpected extra store to address %h", dutOut.adr));
            end else begin
                checkEq("wbOut.adr", dutOut.adr, expStores[storeIdx].adr);
                checkEq("wbOut.datW", dutOut.datW, expStores[storeIdx].dat);
                storeIdx <= storeIdx + 1;
            end
        end
    end

    always @(posedge rstn) begin
        cycles <= cycles + 1;
        if (cycles > timeoutLimit) begin
            failRun($sformatf("timeout, the core did not halt within %0d cycles", timeoutLimit));
        end
    end

    initial begin
        buildProgram();
        loadMemory();
        timeoutLimit = prog.size() * 5 * worstWait + 200;
        repeat (5) @(posedge rstn);
        rst <= 1'b0;
        @(posedge rstn);
        checkEq("wbOut.cyc", 32'(dutOut.cyc), 32'd0);
        checkEq("halted", 32'(halted), 32'd0);
        @(posedge rstn);
        checkEq("wbOut.stb", 32'(dutOut.stb), 32'd1);   // First fetch starts
        while (!halted) begin
            @(posedge rstn);
        end
        if (storeIdx != expStores.size()) begin
            failRun($sformatf("halted too early after %0d of %0d stores",
                              storeIdx, expStores.size()));
        end
        repeat (10) begin
            @(posedge rstn);
            checkEq("wbOut.cyc", 32'(dutOut.cyc), 32'd0);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: verif/rvMemModel.sv
module rvMemModel (
    input  logic            rstn,
    input  logic            rst,
    input  rvPkg::wbMasterT req,
    output rvPkg::wbSlaveT  resp
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0]    mem [1024];   // 4 KiB, word addressed
    integer         seed = 9375;
    rvPkg::wbSlaveT respQ = '0;
    logic [1:0]     waitLeft = 2'd0;

    always @(posedge rstn) begin
        if (rst) begin
            respQ    <= '0;
            waitLeft <= 2'($random(seed));
        end else if (respQ.ack) begin
            respQ.ack <= 1'b0;   // Ack lasts one clock
        end else if (req.cyc && req.stb) begin
            if (waitLeft != 2'd0) begin
                waitLeft <= waitLeft - 2'd1;
            end else begin
                respQ.ack <= 1'b1;
                waitLeft  <= 2'($random(seed));   // Waits for the next access
                if (req.we) begin
                    mem[req.adr[11:2]] <= req.datW;
                end else begin
                    respQ.datR <= mem[req.adr[11:2]];
                end
            end
        end
    end

    assign resp = respQ;

endmodule

// File: rtl/rvCore.sv
`include "rv_params.svh"

module rvCore (
    input  logic            rstn,
    input  logic            rst,
    input  rvPkg::wbSlaveT  wbIn,
    output rvPkg::wbMasterT wbOut,
    output logic            halted
);

    rvPkg::ctrlT         ctrl;
    logic [`RV_XLEN-1:0] ir;
    logic [`RV_XLEN-1:0] loadData;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rd1;
    logic [`RV_XLEN-1:0] rd2;
    logic [`RV_XLEN-1:0] aluB;
    logic [`RV_XLEN-1:0] aluResult;
    logic [`RV_XLEN-1:0] wbValue;
    logic [`RV_XLEN-1:0] pcTarget;
    logic                taken;
    logic                irLoad;
    logic                rdLoad;
    logic                regWrite;
    logic                wbSel;
    logic                pcInc;
    logic                pcLoad;

    always_ff @(posedge rstn) begin
        if (irLoad) begin
            ir <= wbIn.datR;
        end
        if (rdLoad) begin
            loadData <= wbIn.datR;
        end
    end

    always_comb begin
        if (ctrl.instClass == rvPkg::JAL) begin
            aluB = '0;   // JAL reads no register
        end else if (ctrl.useImm) begin
            aluB = imm;
        end else begin
            aluB = rd2;
        end
    end

    always_comb begin
        if (wbSel) begin
            wbValue = loadData;
        end else if (ctrl.instClass == rvPkg::JAL || ctrl.instClass == rvPkg::JALR) begin
            wbValue = pc + `RV_XLEN'd4;   // Link value
        end else begin
            wbValue = aluResult;
        end
    end

    assign pcTarget = (ctrl.instClass == rvPkg::JALR) ? aluResult : pc + imm;

    rvSequencer i_sequencer (
        .rstn      (rstn),
        .rst       (rst),
        .ctrl      (ctrl),
        .taken     (taken),
        .aluResult (aluResult),
        .storeData (rd2),
        .pc        (pc),
        .wbIn      (wbIn),
        .wbOut     (wbOut),
        .irLoad    (irLoad),
        .rdLoad    (rdLoad),
        .regWrite  (regWrite),
        .wbSel     (wbSel),
        .pcInc     (pcInc),
        .pcLoad    (pcLoad),
        .halted    (halted)
    );

    rvPcCounter i_pc (
        .rstn   (rstn),
        .rst    (rst),
        .inc    (pcInc),
        .load   (pcLoad),
        .target (pcTarget),
        .pc     (pc)
    );

    rvDecoder i_decoder (
        .inst (ir),
        .ctrl (ctrl),
        .imm  (imm)
    );

    rvRegFile i_regFile (
        .rstn   (rstn),
        .rs1    (ctrl.rs1),
        .rs2    (ctrl.rs2),
        .rd     (ctrl.rd),
        .wrEn   (regWrite),
        .wrData (wbValue),
        .rd1    (rd1),
        .rd2    (rd2)
    );

    rvAlu i_alu (
        .op     (ctrl.aluOp),
        .a      (rd1),
        .b      (aluB),
        .result (aluResult),
        .taken  (taken)
    );

endmodule

// File: rtl/rvSequencer.sv
`include "rv_params.svh"

module rvSequencer (
    input  logic                rstn,
    input  logic                rst,
    input  rvPkg::ctrlT         ctrl,
    input  logic                taken,
    input  logic [`RV_XLEN-1:0] aluResult,
    input  logic [`RV_XLEN-1:0] storeData,
    input  logic [`RV_XLEN-1:0] pc,
    input  rvPkg::wbSlaveT      wbIn,
    output rvPkg::wbMasterT     wbOut,
    output logic                irLoad,
    output logic                rdLoad,
    output logic                regWrite,
    output logic                wbSel,
    output logic                pcInc,
    output logic                pcLoad,
    output logic                halted
);

    rvPkg::seqStateT state;
    rvPkg::wbMasterT bus;
    logic            busDone;
    logic            isMem;
    logic            jumpNow;

    assign busDone = bus.cyc && wbIn.ack;
    assign isMem   = ctrl.instClass == rvPkg::LOAD || ctrl.instClass == rvPkg::STORE;
    assign jumpNow = ctrl.instClass == rvPkg::JAL || ctrl.instClass == rvPkg::JALR ||
                     (ctrl.instClass == rvPkg::BRANCH && taken);

    always_ff @(posedge rstn) begin
        if (rst) begin
            state <= rvPkg::FETCH;
            bus   <= '0;
        end else begin
            case (state)
                rvPkg::FETCH: begin
                    if (!bus.cyc) begin
                        bus.adr <= pc;   // Instruction read
                        bus.sel <= 4'hF;
                        bus.we  <= 1'b0;
                        bus.cyc <= 1'b1;
                        bus.stb <= 1'b1;
                    end else if (wbIn.ack) begin
                        bus.cyc <= 1'b0;
                        bus.stb <= 1'b0;
                        state   <= rvPkg::DECODE;
                    end
                end
                rvPkg::DECODE: begin
                    if (ctrl.instClass == rvPkg::ILLEGAL) begin
                        state <= rvPkg::HALT;
                    end else begin
                        state <= rvPkg::EXECUTE;
                    end
                end
                rvPkg::EXECUTE: begin
                    if (isMem) begin
                        bus.adr  <= aluResult;
                        bus.datW <= storeData;
                        bus.sel  <= 4'hF;
                        bus.we   <= ctrl.instClass == rvPkg::STORE;
                        bus.cyc  <= 1'b1;
                        bus.stb  <= 1'b1;
                        state    <= rvPkg::MEMORY;
                    end else begin
                        state <= rvPkg::WRITEBACK;
                    end
                end
                rvPkg::MEMORY: begin
                    if (wbIn.ack) begin
                        bus.cyc <= 1'b0;
                        bus.stb <= 1'b0;
                        bus.we  <= 1'b0;
                        state   <= rvPkg::WRITEBACK;
                    end
                end
                rvPkg::WRITEBACK: state <= rvPkg::FETCH;
                default:          state <= rvPkg::HALT;   // Stays here for good
            endcase
        end
    end

    assign wbOut    = bus;
    assign irLoad   = state == rvPkg::FETCH && busDone;
    assign rdLoad   = state == rvPkg::MEMORY && busDone && !bus.we;
    assign wbSel    = ctrl.instClass == rvPkg::LOAD;
    assign regWrite = state == rvPkg::WRITEBACK && ctrl.regWrite;
    assign pcLoad   = state == rvPkg::WRITEBACK && jumpNow;
    assign pcInc    = state == rvPkg::WRITEBACK && !jumpNow;
    assign halted   = state == rvPkg::HALT;

    stbNeedsCyc: assert property (
        @(posedge rstn) disable iff (rst) wbOut.stb |-> wbOut.cyc
    );

    weOnlyInMemory: assert property (
        @(posedge rstn) disable iff (rst) wbOut.we |-> (state == rvPkg::MEMORY)
    );

endmodule

// File: rtl/rvPcCounter.sv
`include "rv_params.svh"

module rvPcCounter (
    input  logic                rstn,
    input  logic                rst,
    input  logic                inc,
    input  logic                load,
    input  logic [`RV_XLEN-1:0] target,
    output logic [`RV_XLEN-1:0] pc
);

    always_ff @(posedge rstn) begin
        if (rst) begin
            pc <= `RV_RESET_VECTOR;
        end else if (load) begin
            pc <= {target[`RV_XLEN-1:1], 1'b0};   // JALR clears bit 0
        end else if (inc) begin
            pc <= pc + `RV_XLEN'd4;
        end
    end

    // Sequencer picks exactly one PC update in writeback
    pcOneUpdate: assert property (
        @(posedge rstn) disable iff (rst) !(inc && load)
    );

endmodule

// File: rtl/rvRegFile.sv
`include "rv_params.svh"

module rvRegFile (
    input  logic                rstn,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [4:0]          rd,
    input  logic                wrEn,
    input  logic [`RV_XLEN-1:0] wrData,
    output logic [`RV_XLEN-1:0] rd1,
    output logic [`RV_XLEN-1:0] rd2
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    always_ff @(posedge rstn) begin
        if (wrEn && rd != 5'd0) begin
            regs[rd] <= wrData;
        end
    end

    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];   // x0 never stored
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

    // A write aimed at x0 must not show up on the next read
    x0StaysZero: assert property (
        @(posedge rstn) (wrEn && rd == 5'd0) |=>
            ((rs1 != 5'd0 || rd1 == '0) && (rs2 != 5'd0 || rd2 == '0))
    );

endmodule

// File: rtl/rvAlu.sv
`include "rv_params.svh"

module rvAlu (
    input  rvPkg::aluOpT        op,
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    output logic [`RV_XLEN-1:0] result,
    output logic                taken
);

    logic [4:0] shamt;
    logic       cond;

    assign shamt = b[4:0];

    always_comb begin
        result = '0;
        cond   = 1'b0;
        case (op)
            rvPkg::ADD:  result = a + b;
            rvPkg::SUB:  result = a - b;
            rvPkg::AND:  result = a & b;
            rvPkg::OR:   result = a | b;
            rvPkg::XOR:  result = a ^ b;
            rvPkg::SLL:  result = a << shamt;
            rvPkg::SRL:  result = a >> shamt;
            rvPkg::SRA:  result = $signed(a) >>> shamt;
            default: begin   // Compares including BLT and BLTU
                case (op)
                    rvPkg::SLT:  cond = $signed(a) < $signed(b);
                    rvPkg::SLTU: cond = a < b;
                    rvPkg::EQ:   cond = a == b;
                    rvPkg::NE:   cond = a != b;
                    rvPkg::GE:   cond = $signed(a) >= $signed(b);
                    default:     cond = a >= b;
                endcase
                result = {{(`RV_XLEN-1){1'b0}}, cond};
            end
        endcase
    end

    assign taken = cond;

endmodule

// File: rtl/rvDecoder.sv
`include "rv_params.svh"

module rvDecoder (
    input  logic [`RV_XLEN-1:0] inst,
    output rvPkg::ctrlT         ctrl,
    output logic [`RV_XLEN-1:0] imm
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] immI;
    logic [`RV_XLEN-1:0] immS;
    logic [`RV_XLEN-1:0] immB;
    logic [`RV_XLEN-1:0] immJ;

    // Shared funct3 map of OP and OP-IMM
    function automatic rvPkg::aluOpT f3ToOp(input logic [2:0] f3);
        case (f3)
            3'b001:  return rvPkg::SLL;
            3'b010:  return rvPkg::SLT;
            3'b011:  return rvPkg::SLTU;
            3'b100:  return rvPkg::XOR;
            3'b101:  return rvPkg::SRL;
            3'b110:  return rvPkg::OR;
            3'b111:  return rvPkg::AND;
            default: return rvPkg::ADD;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl.instClass = rvPkg::ILLEGAL;
        ctrl.aluOp     = rvPkg::ADD;
        ctrl.useImm    = 1'b0;
        ctrl.regWrite  = 1'b0;
        ctrl.rs1       = inst[19:15];
        ctrl.rs2       = inst[24:20];
        ctrl.rd        = inst[11:7];
        case (opcode)
            7'b0110011: begin
                if (funct7 == 7'b0000000) begin
                    ctrl.instClass = rvPkg::ALU_REG;
                    ctrl.aluOp     = f3ToOp(funct3);
                    ctrl.regWrite  = 1'b1;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    ctrl.instClass = rvPkg::ALU_REG;
                    ctrl.aluOp     = rvPkg::SUB;
                    ctrl.regWrite  = 1'b1;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    ctrl.instClass = rvPkg::ALU_REG;
                    ctrl.aluOp     = rvPkg::SRA;
                    ctrl.regWrite  = 1'b1;
                end
            end
            7'b0010011: begin
                if ((funct3 != 3'b001 && funct3 != 3'b101) || funct7 == 7'b0000000) begin
                    ctrl.instClass = rvPkg::ALU_IMM;
                    ctrl.aluOp     = f3ToOp(funct3);
                    ctrl.useImm    = 1'b1;
                    ctrl.regWrite  = 1'b1;
                end else if (funct3 == 3'b101 && funct7 == 7'b0100000) begin
                    ctrl.instClass = rvPkg::ALU_IMM;   // SRAI
                    ctrl.aluOp     = rvPkg::SRA;
                    ctrl.useImm    = 1'b1;
                    ctrl.regWrite  = 1'b1;
                end
            end
            7'b0000011: begin
                if (funct3 == 3'b010) begin
                    ctrl.instClass = rvPkg::LOAD;
                    ctrl.useImm    = 1'b1;
                    ctrl.regWrite  = 1'b1;
                end
            end
            7'b0100011: begin
                if (funct3 == 3'b010) begin
                    ctrl.instClass = rvPkg::STORE;
                    ctrl.useImm    = 1'b1;
                end
            end
            7'b1100011: begin
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    ctrl.instClass = rvPkg::BRANCH;
                    case (funct3)
                        3'b000:  ctrl.aluOp = rvPkg::EQ;
                        3'b001:  ctrl.aluOp = rvPkg::NE;
                        3'b100:  ctrl.aluOp = rvPkg::SLT;
                        3'b101:  ctrl.aluOp = rvPkg::GE;
                        3'b110:  ctrl.aluOp = rvPkg::SLTU;
                        default: ctrl.aluOp = rvPkg::GEU;
                    endcase
                end
            end
            7'b1101111: begin
                ctrl.instClass = rvPkg::JAL;
                ctrl.regWrite  = 1'b1;
            end
            7'b1100111: begin
                if (funct3 == 3'b000) begin
                    ctrl.instClass = rvPkg::JALR;
                    ctrl.useImm    = 1'b1;
                    ctrl.regWrite  = 1'b1;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        case (ctrl.instClass)
            rvPkg::STORE:  imm = immS;
            rvPkg::BRANCH: imm = immB;
            rvPkg::JAL:    imm = immJ;
            default:       imm = immI;
        endcase
    end

endmodule

// File: rtl/rvPkg.sv
`include "rv_params.svh"

package rvPkg;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,     // LW and SW only
        WRITEBACK,
        HALT
    } seqStateT;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR,
        SLT, SLTU, SLL, SRL, SRA,
        EQ, NE, GE, GEU        // Branch-only compares
    } aluOpT;

    typedef enum logic [2:0] {
        ALU_REG, ALU_IMM, LOAD, STORE,
        BRANCH, JAL, JALR, ILLEGAL
    } instClassT;

    typedef struct packed {
        instClassT  instClass;
        aluOpT      aluOp;
        logic       useImm;     // ALU operand b from immediate
        logic       regWrite;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
    } ctrlT;

    typedef struct packed {
        logic [`RV_XLEN-1:0] adr;
        logic [`RV_XLEN-1:0] datW;
        logic [3:0]          sel;
        logic                we;
        logic                cyc;
        logic                stb;
    } wbMasterT;

    typedef struct packed {
        logic [`RV_XLEN-1:0] datR;
        logic                ack;
    } wbSlaveT;

endpackage

// File: rtl/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Core widths fixed by RV32I

`define RV_XLEN 32

// First fetch address after reset
`define RV_RESET_VECTOR 32'h0000_0000

`define RV_NUM_REGS 32

`endif
